//--- build.f
video_pkg.sv
rom_pkg.sv
video_timing.sv
obj_attr_regs.sv
rom_arbiter.sv
obj_shifter.sv
obj_video_top.sv
obj_video_asserts.sv
tb_obj_video.sv

//--- Makefile
# Verilator build and run of the sprite layer testbench

SRCS := $(shell cat build.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_obj_video: build.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_obj_video -f build.f

run: obj_dir/Vtb_obj_video
	./obj_dir/Vtb_obj_video | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- tb_obj_video.sv
////////////////////////////////////////
// tb_obj_video
// clock, reset, APB driver, ROM model
// reference pixel model and checks
// per test report and watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module tb_obj_video;
    import video_pkg::*;
    import rom_pkg::*;

    // 4 checked tests of two frames, one setup frame, margin, plus APB phases
    localparam int unsigned watchdog_ns = (11 * 2 * h_total * v_total + 4096) * 40;

    logic clk, rst_n, psel, penable, pwrite, pready, pslverr, rom_rd, pix_cen;
    logic [apb_aw-1:0] paddr;
    logic [apb_dw-1:0] pwdata, prdata;
    logic [rom_aw-1:0] rom_addr;
    logic [rom_dw-1:0] rom_data, rom_q1, rom_q2;
    logic [h_w-1:0] h_pos;
    logic [v_w-1:0] v_pos;
    logic [pix_w-1:0] obj_pix;
    logic [col_w-1:0] obj_col;

    logic [rom_dw-1:0] rom_mem [1 << rom_aw];
    logic [code_w-1:0] ref_code [num_slots];   // attribute copy for the model
    logic [col_w-1:0] ref_col [num_slots];
    logic [num_slots-1:0] ref_hflip, ref_en;
    logic ref_vflip;
    logic [col_w+pix_w-1:0] exp_pc;            // {colour, pixel}
    bit check_en;
    int seed = 32'he121;
    int fail_cnt, test_cnt;

    obj_video_top i_obj_video_top (.*);

    always #20 clk = ~clk;

    // fixed latency ROM, rom_lat clocks after the strobe
    always @(negedge clk) begin
        rom_q2 <= rom_q1;
        rom_q1 <= rom_rd ? rom_mem[rom_addr] : '0;
    end
    always @(posedge clk) begin
        #2 rom_data = rom_q2;
    end

    function automatic logic [col_w+pix_w-1:0] exp_pixel(input logic [h_w-1:0] h,
                                                       input logic [v_w-1:0] v);
        logic [slot_w-1:0] s;
        logic [2:0] row;
        logic [2:0] col;
        logic [rom_dw-1:0] w;
        s = slot_w'(h / slot_px);
        if (h >= h_w'(h_active) || v >= v_w'(v_active) || !ref_en[s]) return '0;
        row = 3'(v % slot_px) ^ {3{ref_vflip}};
        col = ref_hflip[s] ? 3'd7 - 3'(h % slot_px) : 3'(h % slot_px);
        w = rom_mem[{ref_code[s], row}];
        return {ref_col[s], w[{1'b1, col}], w[{1'b0, col}]};   // plane 1 high byte
    endfunction

    function automatic logic [apb_dw-1:0] attr_word(input logic [slot_w-1:0] s);
        return {19'd0, ref_en[s], ref_hflip[s], ref_col[s], ref_code[s]};
    endfunction

    always_comb exp_pc = exp_pixel(h_pos, v_pos);

    a_reset: assert property (@(posedge clk) !rst_n
        |-> obj_pix == '0 && obj_col == '0 && !rom_rd && pready) else begin
        fail_cnt++;
        $display("Fail %0t reset obj_pix/obj_col/rom_rd/pready exp 0/0/0/1 got %0h/%0h/%0b/%0b",
                 $time, $sampled(obj_pix), $sampled(obj_col), $sampled(rom_rd),
                 $sampled(pready));
    end
    a_pix: assert property (@(posedge clk) disable iff (!check_en)
        pix_cen |-> obj_pix == exp_pc[pix_w-1:0]) else begin
        fail_cnt++;
        $display("Fail %0t obj_pix at h %0d v %0d exp %0h got %0h", $time, $sampled(h_pos),
                 $sampled(v_pos), $sampled(exp_pc[pix_w-1:0]), $sampled(obj_pix));
    end
    a_col: assert property (@(posedge clk) disable iff (!check_en)
        pix_cen |-> obj_col == exp_pc[col_w+pix_w-1:pix_w]) else begin
        fail_cnt++;
        $display("Fail %0t obj_col at h %0d v %0d exp %0h got %0h", $time, $sampled(h_pos),
                 $sampled(v_pos), $sampled(exp_pc[col_w+pix_w-1:pix_w]), $sampled(obj_col));
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got == exp) else begin
            fail_cnt++;
            $display("Fail %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
                            input logic [apb_dw-1:0] wdata,
                            output logic [apb_dw-1:0] rdata, output int waits);
        @(posedge clk);
        #2;
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;   // stable half a clock before completion
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_attrs(input bit hf_alt, input bit en_rand, input bit vf);
        logic [slot_w-1:0] s;
        logic [apb_dw-1:0] rd;
        int waits;
        for (int i = 0; i < num_slots; i++) begin
            s = slot_w'(i);
            ref_code[s] = code_w'($random(seed));
            ref_col[s]  = col_w'($random(seed));
            ref_hflip[s] = hf_alt & s[0];   // every odd slot mirrored
            ref_en[s]    = en_rand ? 1'($random(seed)) : 1'b1;
            apb_xfer(1'b1, reg_attr_base + apb_aw'(i * 4), attr_word(s), rd, waits);
        end
        ref_vflip = vf;
        apb_xfer(1'b1, reg_ctrl, {31'd0, vf}, rd, waits);
    endtask

    task automatic check_readback();
        logic [apb_dw-1:0] rd;
        int waits;
        for (int i = 0; i < num_slots; i++) begin
            apb_xfer(1'b0, reg_attr_base + apb_aw'(i * 4), '0, rd, waits);
            check_value("prdata attr", attr_word(slot_w'(i)), rd);
            check_value("pready wait states", 32'd0, waits);   // no stall off the peek data
        end
        apb_xfer(1'b0, reg_ctrl, '0, rd, waits);
        check_value("prdata ctrl", {31'd0, ref_vflip}, rd);
        check_value("pready wait states", 32'd0, waits);
    endtask

    task automatic peek_reads(input int n);
        logic [rom_aw-1:0] a;
        logic [apb_dw-1:0] rd;
        int waits;
        repeat (n) begin
            a = rom_aw'($random(seed));
            apb_xfer(1'b1, reg_peek_addr, {21'd0, a}, rd, waits);
            apb_xfer(1'b0, reg_peek_data, '0, rd, waits);
            check_value("prdata peek", {16'd0, rom_mem[a]}, rd);
            assert (waits > 0) else begin
                fail_cnt++;
                $display("peek read at %0t finished with no wait state", $time);
            end
        end
    endtask

    // tag of the first pixel of a frame, after a vblank line
    task automatic wait_frame_start();
        do @(negedge clk); while (!(pix_cen && v_pos == v_w'(v_active) && h_pos == '0));
        do @(negedge clk); while (!(pix_cen && v_pos == '0 && h_pos == '0));
    endtask

    task automatic run_frame(input bit with_peek);
        wait_frame_start();
        #2 check_en = 1'b1;
        fork
            wait_frame_start();
            if (with_peek) peek_reads(16);
        join
        #2 check_en = 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s done, %0d failures so far", test_cnt, name, fail_cnt);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, tests did not finish", $time);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rom_data = '0;
        for (int i = 0; i < (1 << rom_aw); i++) rom_mem[rom_aw'(i)] = rom_dw'($random(seed));
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        finish_test("reset state");
        load_attrs(1'b1, 1'b1, 1'b1);
        check_readback();
        finish_test("apb read-back");
        load_attrs(1'b0, 1'b0, 1'b0);
        run_frame(1'b0);
        finish_test("pixel rendering");
        load_attrs(1'b1, 1'b0, 1'b1);
        run_frame(1'b0);
        finish_test("flips");
        load_attrs(1'b0, 1'b1, 1'b0);
        run_frame(1'b0);
        finish_test("zero outputs");
        load_attrs(1'b1, 1'b1, 1'b0);
        run_frame(1'b1);
        finish_test("peek");
        $display("tests %0d, failures %0d", test_cnt, fail_cnt);
        if (fail_cnt == 0) $display("TB PASSED");
        else $display("TB FAILED");
        $finish;
    end

endmodule

//--- obj_video_asserts.sv
////////////////////////////////////////
// obj_video_asserts
// ROM return, APB and blanking checks
// bind onto obj_video_top
////////////////////////////////////////

`timescale 1ns/1ps

module obj_video_asserts (
    input logic                         clk,
    input logic                         rst_n,
    input logic [rom_pkg::apb_aw-1:0]   paddr,
    input logic                         psel,
    input logic                         penable,
    input logic                         pready,
    input logic                         pslverr,
    input logic                         rom_rd,
    input logic                         vid_valid,
    input logic                         peek_valid,
    input logic                         pix_cen,
    input logic [video_pkg::h_w-1:0]    h_pos,
    input logic [video_pkg::v_w-1:0]    v_pos,
    input logic [video_pkg::pix_w-1:0]  obj_pix,
    input logic [video_pkg::col_w-1:0]  obj_col
);
    import video_pkg::*;
    import rom_pkg::*;

    // one owner per ROM strobe, word back after rom_lat
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        rom_rd |-> ##rom_lat (vid_valid ^ peek_valid))
        else $error("ROM read returned to no owner or to both owners");

    a_no_slverr: assert property (@(posedge clk) disable iff (!rst_n)
        !pslverr) else $error("pslverr raised");

    // tags mark blanked pixels
    a_blank_zero: assert property (@(posedge clk) disable iff (!rst_n)
        pix_cen && (h_pos >= h_w'(h_active) || v_pos >= v_w'(v_active))
        |-> obj_pix == '0 && obj_col == '0) else $error("pixel not zero in blanking");

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pready |=> $stable(paddr)) else $error("paddr moved in stall");

endmodule

bind obj_video_top obj_video_asserts i_obj_video_asserts (
    .clk, .rst_n, .paddr, .psel, .penable, .pready, .pslverr,
    .rom_rd, .vid_valid, .peek_valid, .pix_cen, .h_pos, .v_pos, .obj_pix, .obj_col
);

//--- obj_video_top.sv
////////////////////////////////////////
// obj_video_top
// timing, attribute regs, ROM arbiter
// and pixel shifter
////////////////////////////////////////

`timescale 1ns/1ps

module obj_video_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // APB slave
    input  logic [rom_pkg::apb_aw-1:0]    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [rom_pkg::apb_dw-1:0]    pwdata,
    output logic [rom_pkg::apb_dw-1:0]    prdata,
    output logic                          pready,
    output logic                          pslverr,
    // graphics ROM
    output logic                          rom_rd,
    output logic [rom_pkg::rom_aw-1:0]    rom_addr,
    input  logic [rom_pkg::rom_dw-1:0]    rom_data,
    // tagged pixels
    output logic                          pix_cen,
    output logic [video_pkg::h_w-1:0]     h_pos,
    output logic [video_pkg::v_w-1:0]     v_pos,
    output logic [video_pkg::pix_w-1:0]   obj_pix,
    output logic [video_pkg::col_w-1:0]   obj_col
);
    import video_pkg::*;
    import rom_pkg::*;

    logic              tim_cen;   // raster enable, before output register
    logic [h_w-1:0]    h_cnt;
    logic [v_w-1:0]    v_cnt;
    logic              hblank, vblank;
    logic [slot_w-1:0] slot;
    logic [code_w-1:0] attr_code;
    logic [col_w-1:0]  attr_col;
    logic              attr_hflip, attr_en, vflip;
    logic              vid_req, vid_gnt, vid_valid;
    logic [rom_aw-1:0] vid_addr;
    logic              peek_req, peek_gnt, peek_valid;
    logic [rom_aw-1:0] peek_addr;
    logic [rom_dw-1:0] rd_data;

    video_timing i_video_timing (
        .clk, .rst_n, .pix_cen(tim_cen), .h_cnt, .v_cnt, .hblank, .vblank
    );

    obj_attr_regs i_obj_attr_regs (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .slot, .attr_code, .attr_col, .attr_hflip, .attr_en, .vflip,
        .peek_req, .peek_addr, .peek_gnt, .peek_valid, .peek_data(rd_data)
    );

    // video fetch first, CPU peek second
    rom_arbiter i_rom_arbiter (
        .clk, .rst_n,
        .vid_req, .vid_addr, .vid_gnt, .vid_valid,
        .cpu_req(peek_req), .cpu_addr(peek_addr), .cpu_gnt(peek_gnt), .cpu_valid(peek_valid),
        .rd_data, .rom_rd, .rom_addr, .rom_data
    );

    obj_shifter i_obj_shifter (
        .clk, .rst_n, .pix_cen(tim_cen), .h_cnt, .v_cnt, .hblank, .vblank,
        .slot, .attr_code, .attr_col, .attr_hflip, .attr_en, .vflip,
        .vid_req, .vid_addr, .vid_gnt, .vid_valid, .rd_data,
        .pix_cen_o(pix_cen), .h_pos, .v_pos, .obj_pix, .obj_col
    );

endmodule

//--- obj_shifter.sv
////////////////////////////////////////
// obj_shifter
// next slot fetch, tile word load
// flip aware 2-plane pixel shifter
////////////////////////////////////////

`timescale 1ns/1ps

module obj_shifter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pix_cen,
    input  logic [video_pkg::h_w-1:0]      h_cnt,
    input  logic [video_pkg::v_w-1:0]      v_cnt,
    input  logic                           hblank,
    input  logic                           vblank,
    output logic [video_pkg::slot_w-1:0]   slot,
    input  logic [video_pkg::code_w-1:0]   attr_code,
    input  logic [video_pkg::col_w-1:0]    attr_col,
    input  logic                           attr_hflip,
    input  logic                           attr_en,
    input  logic                           vflip,
    output logic                           vid_req,
    output logic [rom_pkg::rom_aw-1:0]     vid_addr,
    input  logic                           vid_gnt,
    input  logic                           vid_valid,
    input  logic [rom_pkg::rom_dw-1:0]     rd_data,
    output logic                           pix_cen_o,
    output logic [video_pkg::h_w-1:0]      h_pos,
    output logic [video_pkg::v_w-1:0]      v_pos,
    output logic [video_pkg::pix_w-1:0]    obj_pix,
    output logic [video_pkg::col_w-1:0]    obj_col
);
    import video_pkg::*;
    import rom_pkg::*;

    logic [h_w:0]       h_ahead;   // one slot ahead, may pass h_total
    logic [h_w:0]       h_disp;
    logic               wrap;      // next slot is on the next line
    logic [v_w-1:0]     v_disp;
    logic [row_w-1:0]   row;
    logic               fetch_stb;
    logic               load_stb;
    logic [rom_dw-1:0]  word_q;
    logic [slot_px-1:0] plane1, plane0;
    logic [col_w-1:0]   pend_col, cur_col;
    logic               pend_hflip, pend_en, cur_hflip, cur_en;

    assign h_ahead = {1'b0, h_cnt} + (h_w+1)'(slot_px);
    assign wrap    = (h_ahead >= (h_w+1)'(h_total));
    assign h_disp  = wrap ? h_ahead - (h_w+1)'(h_total) : h_ahead;
    assign v_disp  = wrap ? v_cnt + 1'b1 : v_cnt;   // v_total is a multiple of 8
    assign slot    = h_disp[px_lsb +: slot_w];
    assign row     = v_disp[row_w-1:0] ^ {row_w{vflip}};

    assign fetch_stb = pix_cen & (h_cnt[px_lsb-1:0] == 3'd1);
    assign load_stb  = pix_cen & (h_cnt[px_lsb-1:0] == 3'd7);

    always_ff @(posedge clk) begin
        if (fetch_stb) begin
            vid_addr <= {attr_code, row};
            pend_col <= attr_col;
        end
        if (vid_valid) word_q <= rd_data;
        if (load_stb) begin
            plane1  <= word_q[rom_dw-1 -: slot_px];
            plane0  <= word_q[slot_px-1:0];
            cur_col <= pend_col;
        end else if (pix_cen) begin
            plane1 <= cur_hflip ? {plane1[slot_px-2:0], 1'b0} : {1'b0, plane1[slot_px-1:1]};
            plane0 <= cur_hflip ? {plane0[slot_px-2:0], 1'b0} : {1'b0, plane0[slot_px-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vid_req    <= 1'b0;
            pend_hflip <= 1'b0;
            pend_en    <= 1'b0;
            cur_hflip  <= 1'b0;
            cur_en     <= 1'b0;
            pix_cen_o  <= 1'b0;
            h_pos      <= '0;
            v_pos      <= '0;
            obj_pix    <= '0;
            obj_col    <= '0;
        end else begin
            if (fetch_stb) begin
                vid_req    <= 1'b1;        // held until granted
                pend_hflip <= attr_hflip;
                pend_en    <= attr_en;
            end else if (vid_gnt) begin
                vid_req <= 1'b0;
            end
            if (load_stb) begin
                cur_hflip <= pend_hflip;
                cur_en    <= pend_en;
            end
            pix_cen_o <= pix_cen;          // outputs move with their tags
            if (pix_cen) begin
                h_pos <= h_cnt;
                v_pos <= v_cnt;
                if (hblank || vblank || !cur_en) begin
                    obj_pix <= '0;
                    obj_col <= '0;
                end else begin
                    obj_pix <= cur_hflip ? {plane1[slot_px-1], plane0[slot_px-1]}
                                         : {plane1[0], plane0[0]};
                    obj_col <= cur_col;
                end
            end
        end
    end

endmodule

//--- rom_arbiter.sv
////////////////////////////////////////
// rom_arbiter
// fixed priority, video over CPU peek
// owner tag delay line routes returns
////////////////////////////////////////

`timescale 1ns/1ps

module rom_arbiter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       vid_req,
    input  logic [rom_pkg::rom_aw-1:0] vid_addr,
    output logic                       vid_gnt,
    output logic                       vid_valid,
    input  logic                       cpu_req,
    input  logic [rom_pkg::rom_aw-1:0] cpu_addr,
    output logic                       cpu_gnt,
    output logic                       cpu_valid,
    output logic [rom_pkg::rom_dw-1:0] rd_data,
    output logic                       rom_rd,
    output logic [rom_pkg::rom_aw-1:0] rom_addr,
    input  logic [rom_pkg::rom_dw-1:0] rom_data
);
    import rom_pkg::*;

    // one-hot owner per stage, bit 0 video, bit 1 cpu
    // stage 0 lines up with rom_rd, stage rom_lat with rom_data
    logic [1:0] tag_q [rom_lat+1];

    // video wins any tie, one grant per clock
    assign vid_gnt = vid_req;
    assign cpu_gnt = cpu_req & ~vid_req;

    assign rom_rd    = |tag_q[0];
    assign vid_valid = tag_q[rom_lat][0];
    assign cpu_valid = tag_q[rom_lat][1];
    assign rd_data   = rom_data;   // shared return bus, qualified by the valids

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= rom_lat; i++) begin
                tag_q[i] <= '0;
            end
        end else begin
            tag_q[0] <= {cpu_gnt, vid_gnt};
            for (int i = 1; i <= rom_lat; i++) begin
                tag_q[i] <= tag_q[i-1];   // reads may overlap
            end
        end
    end

    // address registered with the strobe
    always_ff @(posedge clk) begin
        if (vid_gnt) begin
            rom_addr <= vid_addr;
        end else if (cpu_gnt) begin
            rom_addr <= cpu_addr;
        end
    end

endmodule

//--- obj_attr_regs.sv
////////////////////////////////////////
// obj_attr_regs
// APB slave, slot attribute table
// vflip control, ROM peek registers
////////////////////////////////////////

`timescale 1ns/1ps

module obj_attr_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [rom_pkg::apb_aw-1:0]     paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [rom_pkg::apb_dw-1:0]     pwdata,
    output logic [rom_pkg::apb_dw-1:0]     prdata,
    output logic                           pready,
    output logic                           pslverr,
    input  logic [video_pkg::slot_w-1:0]   slot,
    output logic [video_pkg::code_w-1:0]   attr_code,
    output logic [video_pkg::col_w-1:0]    attr_col,
    output logic                           attr_hflip,
    output logic                           attr_en,
    output logic                           vflip,
    output logic                           peek_req,
    output logic [rom_pkg::rom_aw-1:0]     peek_addr,
    input  logic                           peek_gnt,
    input  logic                           peek_valid,
    input  logic [rom_pkg::rom_dw-1:0]     peek_data
);
    import video_pkg::*;
    import rom_pkg::*;

    logic [code_w-1:0]    code_mem [num_slots];
    logic [col_w-1:0]     col_mem  [num_slots];
    logic [num_slots-1:0] hflip_mem;
    logic [num_slots-1:0] en_q;          // enables cleared on reset
    logic [rom_dw-1:0]    peek_q;        // last word read from ROM
    logic                 peek_done;
    logic [apb_aw-1:0]    attr_off;
    logic [slot_w-1:0]    idx;
    logic                 is_attr;
    logic                 wr_en;
    logic                 peek_rd;

    assign attr_off = paddr - reg_attr_base;
    assign idx      = attr_off[2 +: slot_w];  // word aligned
    assign is_attr  = (paddr < reg_ctrl);
    assign wr_en    = psel & penable & pwrite;
    assign peek_rd  = psel & ~pwrite & (paddr == reg_peek_data);

    // stall only the peek data read until the word is back
    assign pready  = ~(peek_rd & penable) | peek_done;
    assign pslverr = 1'b0;

    // attribute lookup for the shifter
    assign attr_code  = code_mem[slot];
    assign attr_col   = col_mem[slot];
    assign attr_hflip = hflip_mem[slot];
    assign attr_en    = en_q[slot];

    always_ff @(posedge clk) begin
        if (wr_en && is_attr) begin
            code_mem[idx]  <= pwdata[attr_code_lsb +: code_w];
            col_mem[idx]   <= pwdata[attr_col_lsb +: col_w];
            hflip_mem[idx] <= pwdata[attr_hflip_bit];
        end
        if (wr_en && paddr == reg_peek_addr) peek_addr <= pwdata[rom_aw-1:0];
        if (peek_valid) peek_q <= peek_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q      <= '0;
            vflip     <= 1'b0;
            peek_req  <= 1'b0;
            peek_done <= 1'b0;
        end else begin
            if (wr_en && is_attr) en_q[idx] <= pwdata[attr_en_bit];
            if (wr_en && paddr == reg_ctrl) vflip <= pwdata[0];
            if (peek_rd && !penable) begin
                peek_req <= 1'b1;          // setup phase starts the ROM read
            end else if (peek_gnt) begin
                peek_req <= 1'b0;
            end
            if (peek_rd && penable && peek_done) begin
                peek_done <= 1'b0;         // transfer done
            end else if (peek_valid) begin
                peek_done <= 1'b1;
            end
        end
    end

    // read-back mux
    always_comb begin
        prdata = '0;
        if (is_attr) begin
            prdata[attr_code_lsb +: code_w] = code_mem[idx];
            prdata[attr_col_lsb +: col_w]   = col_mem[idx];
            prdata[attr_hflip_bit]          = hflip_mem[idx];
            prdata[attr_en_bit]             = en_q[idx];
        end else begin
            case (paddr)
                reg_ctrl:      prdata[0]          = vflip;
                reg_peek_addr: prdata[rom_aw-1:0] = peek_addr;
                reg_peek_data: prdata[rom_dw-1:0] = peek_q;
                default:       prdata             = '0;
            endcase
        end
    end

endmodule

//--- video_timing.sv
////////////////////////////////////////
// video_timing
// pixel enable at clk/2, h and v counters
// registered blanking flags
////////////////////////////////////////

`timescale 1ns/1ps

module video_timing (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    pix_cen,
    output logic [video_pkg::h_w-1:0] h_cnt,
    output logic [video_pkg::v_w-1:0] v_cnt,
    output logic                    hblank,
    output logic                    vblank
);
    import video_pkg::*;

    logic           h_last;   // last enable of the line
    logic           v_last;
    logic [h_w-1:0] h_next;
    logic [v_w-1:0] v_next;

    assign h_last = (h_cnt == h_w'(h_total - 1));
    assign v_last = (v_cnt == v_w'(v_total - 1));
    assign h_next = h_last ? '0 : h_cnt + 1'b1;

    // line counter only moves at end of line
    always_comb begin
        v_next = v_cnt;
        if (h_last) begin
            v_next = v_last ? '0 : v_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cen <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
            hblank  <= 1'b0;
            vblank  <= 1'b0;
        end else begin
            pix_cen <= ~pix_cen;   // high every second clk
            if (pix_cen) begin
                h_cnt  <= h_next;
                v_cnt  <= v_next;
                hblank <= (h_next >= h_w'(h_active)); // flags track the counters
                vblank <= (v_next >= v_w'(v_active));
            end
        end
    end

endmodule

//--- rom_pkg.sv
////////////////////////////////////////
// graphics ROM widths and latency
// APB register map, attribute layout
////////////////////////////////////////

package rom_pkg;

    localparam int unsigned row_w   = 3;      // tile row inside the address
    localparam int unsigned rom_aw  = 11;     // {code, row}
    localparam int unsigned rom_dw  = 16;     // plane 1 high byte, plane 0 low byte
    localparam int unsigned rom_lat = 2;      // strobe to data, in clk

    localparam int unsigned apb_aw = 8;
    localparam int unsigned apb_dw = 32;

    localparam logic [apb_aw-1:0] reg_attr_base = 8'h00; // one word per slot
    localparam logic [apb_aw-1:0] reg_ctrl      = 8'h80; // bit 0 vflip
    localparam logic [apb_aw-1:0] reg_peek_addr = 8'h84;
    localparam logic [apb_aw-1:0] reg_peek_data = 8'h88;

    // attribute word fields
    localparam int unsigned attr_code_lsb  = 0;
    localparam int unsigned attr_col_lsb   = 8;
    localparam int unsigned attr_hflip_bit = 11;
    localparam int unsigned attr_en_bit    = 12;

endpackage

//--- video_pkg.sv
////////////////////////////////////////
// raster sizes for the sprite layer
// slot geometry and field widths
////////////////////////////////////////

package video_pkg;

    // raster, counted in pixel enables
    localparam int unsigned h_total  = 288;   // pixel enables per line
    localparam int unsigned h_active = 256;   // visible pixels
    localparam int unsigned v_total  = 240;   // lines per frame
    localparam int unsigned v_active = 224;   // visible lines

    localparam int unsigned h_w = 9;          // horizontal counter width
    localparam int unsigned v_w = 9;          // vertical counter width

    // slot geometry
    localparam int unsigned slot_px   = 8;    // pixels per slot
    localparam int unsigned num_slots = 32;
    localparam int unsigned slot_w    = $clog2(num_slots);
    localparam int unsigned px_lsb    = $clog2(slot_px); // h bit where slot index starts

    // attribute and pixel fields
    localparam int unsigned code_w = 8;       // tile code
    localparam int unsigned col_w  = 3;       // colour
    localparam int unsigned pix_w  = 2;       // two planes

endpackage
